//--- Bender.yml
package:
  name: nx1_io

sources:
  # rtl, package first
  - source/nx1_pkg.sv
  - source/nx1_spi_ctl_if.sv
  - source/nx1_clkgen.sv
  - source/nx1_bus_slave.sv
  - source/nx1_mmc_spi.sv
  - source/nx1_io_top.sv

  # testbench, pulls in test/tb_nx1_tests.svh
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_nx1_io.sv

//--- build.f
+incdir+test
source/nx1_pkg.sv
source/nx1_spi_ctl_if.sv
source/nx1_clkgen.sv
source/nx1_bus_slave.sv
source/nx1_mmc_spi.sv
source/nx1_io_top.sv
test/tb_nx1_io.sv

//--- source/nx1_bus_slave.sv
`default_nettype none

module nx1_bus_slave (
  input  logic                         clk32M,
  input  logic                         sys_reset,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [nx1_pkg::ADDR_W-1:0]   paddr,
  input  logic [nx1_pkg::DATA_W-1:0]   pwdata,
  output logic [nx1_pkg::DATA_W-1:0]   prdata,
  output logic                         pready,
  nx1_spi_ctl_if.bus                   spi
);

  nx1_pkg::spi_addr_u addr_v;   // paddr seen as command
  logic               setup;    // apb setup phase
  logic               access;   // apb access phase
  logic               win_hit;  // address inside the spi window
  logic               win_q;    // window decode, held through the access
  logic               done;     // transfer completes this edge

  // --------------------
  // address decode
  // --------------------
  assign addr_v.raw = paddr;
  assign win_hit    = (addr_v.cmd.page == nx1_pkg::SPI_PAGE);

  assign setup  = psel & ~penable;
  assign access = psel & penable;

  // decode latched in setup, paddr is stable for the whole transfer
  always_ff @(posedge clk32M or posedge sys_reset)
  begin
    if (sys_reset)
    begin
      win_q <= 1'b0;
    end
    else if (setup)
    begin
      win_q <= win_hit;
    end
    else if (done)
    begin
      win_q <= 1'b0;                    // back to idle
    end
  end

  // --------------------
  // wait generation
  // --------------------
  // only the window stalls, everything else is zero wait
  assign pready = ~(win_q & spi.busy);
  assign done   = access & pready;

  // --------------------
  // spi command issue
  // --------------------
  // one start per completed window write, engine latches on this edge
  assign spi.start = done & pwrite & win_q;
  assign spi.cmd   = addr_v;            // count, select and keep from a[6:0]
  assign spi.wdata = pwdata;

  // --------------------
  // read multiplexer
  // --------------------
  // only two sources left, window or floating bus
  always_comb
  begin
    if (win_q)
      prdata = spi.rdata;               // shift register, rx byte
    else
      prdata = nx1_pkg::BUS_FREE;       // nobody drives, pull-ups
  end

endmodule

`default_nettype wire

//--- source/nx1_clkgen.sv
`default_nettype none

module nx1_clkgen (
  input  logic clk32M,
  input  logic clk_reset,
  input  logic ipl_n,       // front panel ipl button, low active
  output logic cpu_clk,     // 4 MHz, even duty
  output logic clk2m,       // 2 MHz for psg style timing
  output logic sys_reset
);

  logic [3:0] presc;        // free running /16
  logic       reset_dly;    // power-on hold
  logic [2:0] cpu_div;      // /8 for the cpu clock
  logic       cpu_rise;     // registered rise flag
  logic       cpu_fall;     // registered fall flag

  // --------------------
  // prescaler, also the 2 MHz source
  // --------------------
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
    begin
      presc <= 4'd0;
    end
    else
    begin
      presc <= presc + 4'd1;
    end
  end

  assign clk2m = presc[3];  // 8 high, 8 low

  // --------------------
  // system reset
  // --------------------
  // held until the prescaler wraps once, 16 edges
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
    begin
      reset_dly <= 1'b1;
    end
    else if (presc == nx1_pkg::RESET_HOLD)
    begin
      reset_dly <= 1'b0;
    end
  end

  assign sys_reset = reset_dly | ~ipl_n;    // ipl button restarts the io side too

  // --------------------
  // cpu clock divider
  // --------------------
  // flags are one cycle late, so the divider restarts on the cycle after count 6
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
    begin
      cpu_div  <= 3'd0;
      cpu_rise <= 1'b0;
      cpu_fall <= 1'b0;
      cpu_clk  <= 1'b0;
    end
    else
    begin
      cpu_div  <= cpu_rise ? 3'd0 : cpu_div + 3'd1;       // period 8
      cpu_rise <= (cpu_div == nx1_pkg::CPU_RISE_CNT);
      cpu_fall <= (cpu_div == nx1_pkg::CPU_FALL_CNT);
      if (cpu_rise)
        cpu_clk <= 1'b1;                                  // high at div 0..3
      else if (cpu_fall)
        cpu_clk <= 1'b0;                                  // low at div 4..7
    end
  end

endmodule

`default_nettype wire

//--- source/nx1_io_top.sv
`default_nettype none

module nx1_io_top (
  input  logic                         clk32M,
  input  logic                         clk_reset,
  input  logic                         ipl_n,

  // apb slave port
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [nx1_pkg::ADDR_W-1:0]   paddr,
  input  logic [nx1_pkg::DATA_W-1:0]   pwdata,
  output logic [nx1_pkg::DATA_W-1:0]   prdata,
  output logic                         pready,

  // mmc card
  output logic                         mmc_clk,
  output logic                         mmc_cs,
  output logic                         mmc_dout,
  input  logic                         mmc_din,

  // derived clocks
  output logic                         cpu_clk,
  output logic                         clk2m
);

  logic sys_reset;      // delayed reset or ipl

  nx1_spi_ctl_if spi_ctl ();

  // --------------------
  // clocks and reset
  // --------------------
  nx1_clkgen u_clkgen (
    .clk32M    (clk32M),
    .clk_reset (clk_reset),
    .ipl_n     (ipl_n),
    .cpu_clk   (cpu_clk),
    .clk2m     (clk2m),
    .sys_reset (sys_reset)
  );

  // --------------------
  // bus side
  // --------------------
  nx1_bus_slave u_bus_slave (
    .clk32M    (clk32M),
    .sys_reset (sys_reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .spi       (spi_ctl.bus)
  );

  // --------------------
  // mmc spi
  // --------------------
  nx1_mmc_spi u_mmc_spi (
    .clk32M    (clk32M),
    .sys_reset (sys_reset),
    .spi       (spi_ctl.engine),
    .mmc_clk   (mmc_clk),
    .mmc_cs    (mmc_cs),
    .mmc_dout  (mmc_dout),
    .mmc_din   (mmc_din)
  );

endmodule

`default_nettype wire

//--- source/nx1_mmc_spi.sv
`default_nettype none

module nx1_mmc_spi (
  input  logic        clk32M,
  input  logic        sys_reset,
  nx1_spi_ctl_if.engine spi,
  output logic        mmc_clk,    // spi clock, idle low
  output logic        mmc_cs,     // card select, low active
  output logic        mmc_dout,   // to card di / sd cmd
  input  logic        mmc_din     // from card do / sd dat0
);

  logic                         sclk;     // serial clock state
  logic                         sel;      // latched mmc_sel
  logic [3:0]                   cnt;      // bits left
  logic [nx1_pkg::DATA_W-1:0]   sreg;     // shift register, lsb out first
  logic                         dout;     // output bit register
  logic                         din_g;    // gated serial input

  // --------------------
  // input gating
  // --------------------
  // card off, zeros shift in
  assign din_g = sel ? mmc_din : 1'b0;

  // --------------------
  // shift engine
  // --------------------
  always_ff @(posedge clk32M or posedge sys_reset)
  begin
    if (sys_reset)
    begin
      sclk <= 1'b0;
      sel  <= 1'b0;
      cnt  <= 4'd0;
      sreg <= '0;
      dout <= 1'b0;
    end
    else if (spi.start)
    begin
      // new command, slave only starts us when idle
      cnt <= spi.cmd.cmd.bit_cnt;
      sel <= spi.cmd.cmd.mmc_sel;
      if (!spi.cmd.cmd.keep)
        sreg <= spi.wdata;                  // else continue on old contents
    end
    else if (cnt != 4'd0)
    begin
      sclk <= ~sclk;                        // two cycles per bit
      if (!sclk)
      begin
        // rising edge of mmc_clk
        dout <= sreg[0];                    // lsb first out
        sreg <= {din_g, sreg[nx1_pkg::DATA_W-1:1]}; // lsb first in
      end
      else
      begin
        cnt <= cnt - 4'd1;                  // falling edge ends the bit
      end
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign mmc_clk  = sclk;
  assign mmc_cs   = ~sel;
  assign mmc_dout = dout;

  assign spi.busy  = (cnt != 4'd0);
  assign spi.rdata = sreg;                  // readable any time, stable when idle

endmodule

`default_nettype wire

//--- source/nx1_pkg.sv
`default_nettype none

package nx1_pkg;

  // --------------------
  // bus geometry
  // --------------------
  localparam int ADDR_W = 16;                   // apb address, z80 style
  localparam int DATA_W = 8;                    // byte wide data path

  // --------------------
  // clock generator
  // --------------------
  localparam logic [2:0] CPU_RISE_CNT = 3'd6;   // divider count flagging cpu_clk rise
  localparam logic [2:0] CPU_FALL_CNT = 3'd2;   // divider count flagging cpu_clk fall
  localparam logic [3:0] RESET_HOLD   = 4'd15;  // last prescaler count of sys_reset

  // --------------------
  // read path / spi window
  // --------------------
  localparam logic [DATA_W-1:0] BUS_FREE = 8'hff; // pulled-up data bus, unmapped reads

  // a[15:7] of the window, 0x1a00..0x1a7f
  localparam logic [8:0] SPI_PAGE = 9'h034;

  // one bus address, seen either as a plain word or as an spi command
  // the command rides in the low address bits, data byte is the shift value
  typedef union packed {
    logic [ADDR_W-1:0] raw;                     // address as driven on the bus
    struct packed {
      logic [8:0] page;                         // window select, compare to SPI_PAGE
      logic       keep;                         // 1 = leave shift register as is
      logic       mmc_sel;                      // bit 5, card select
      logic       unused;                       // bit 4, was config rom select
      logic [3:0] bit_cnt;                      // bits to shift, 0 = no transfer
    } cmd;
  } spi_addr_u;

  // window layout at a glance
  //   0x1a0n  load byte, shift n bits, card off
  //   0x1a2n  load byte, shift n bits, card on
  //   0x1a6n  keep register, shift n bits, card on

endpackage

`default_nettype wire

//--- source/nx1_spi_ctl_if.sv
`default_nettype none

// command / status link between apb slave and mmc shift engine
interface nx1_spi_ctl_if;

  // --------------------
  // slave -> engine
  // --------------------
  logic                         start;  // one cycle, command accepted
  nx1_pkg::spi_addr_u           cmd;    // address word holding the command fields
  logic [nx1_pkg::DATA_W-1:0]   wdata;  // byte to load, unless keep

  // --------------------
  // engine -> slave
  // --------------------
  logic                         busy;   // bit counter not yet zero
  logic [nx1_pkg::DATA_W-1:0]   rdata;  // live shift register

  modport bus (
    output start, cmd, wdata,
    input  busy, rdata
  );

  modport engine (
    input  start, cmd, wdata,
    output busy, rdata
  );

endinterface

`default_nettype wire

//--- test/tb_nx1_tests.svh
`ifndef TB_NX1_TESTS_SVH
`define TB_NX1_TESTS_SVH

// --------------------
// compare tasks
// --------------------
task automatic check_byte(input logic [nx1_pkg::DATA_W-1:0] got,
                          input logic [nx1_pkg::DATA_W-1:0] exp, input string what);
  if (got !== exp)
  begin
    $display("error @%0t: %s, got 0x%h expected 0x%h", $time, what, got, exp);
    byte_errs++;
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp)
  begin
    $display("error @%0t: %s, got %b expected %b", $time, what, got, exp);
    bit_errs++;
  end
endtask

// exact when lo == hi
task automatic check_count(input int got, input int lo, input int hi, input string what);
  if (got < lo || got > hi)
  begin
    $display("error @%0t: %s, got %0d expected %0d..%0d", $time, what, got, lo, hi);
    count_errs++;
  end
endtask

// --------------------
// apb master
// --------------------
function automatic logic [nx1_pkg::ADDR_W-1:0] window_addr(input logic keep, input logic sel,
                                                           input logic [3:0] n_bits);
  nx1_pkg::spi_addr_u a;
  a.raw         = '0;
  a.cmd.page    = nx1_pkg::SPI_PAGE;
  a.cmd.keep    = keep;
  a.cmd.mmc_sel = sel;
  a.cmd.bit_cnt = n_bits;
  return a.raw;
endfunction

task automatic apb_xfer(input logic wr, input logic [nx1_pkg::ADDR_W-1:0] addr,
                        input logic [nx1_pkg::DATA_W-1:0] wdata,
                        output logic [nx1_pkg::DATA_W-1:0] rdata, output int waits);
  @(negedge clk32M);
  psel    = 1'b1;                                // setup phase
  penable = 1'b0;
  pwrite  = wr;
  paddr   = addr;
  pwdata  = wdata;
  @(negedge clk32M);
  penable = 1'b1;
  waits   = 0;
  while (pready !== 1'b1)                        // slave stalls on busy engine
  begin
    @(negedge clk32M);
    waits++;
  end
  rdata = prdata;                                // taken on the coming edge
  @(negedge clk32M);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [nx1_pkg::ADDR_W-1:0] addr,
                         input logic [nx1_pkg::DATA_W-1:0] data);
  logic [nx1_pkg::DATA_W-1:0] rd;
  int waits;
  apb_xfer(1'b1, addr, data, rd, waits);
endtask

task automatic apb_read(input logic [nx1_pkg::ADDR_W-1:0] addr,
                        output logic [nx1_pkg::DATA_W-1:0] data, output int waits);
  apb_xfer(1'b0, addr, '0, data, waits);
endtask

// --------------------
// directed tests
// --------------------
task automatic test_clocks();
  time t_rise;
  time t_fall;
  time t_next;
  @(posedge cpu_clk);
  t_rise = $time;
  @(negedge cpu_clk);
  t_fall = $time;
  @(posedge cpu_clk);
  t_next = $time;
  check_count(int'((t_fall - t_rise) / CLK_PERIOD), 4, 4, "cpu_clk high cycles");
  check_count(int'((t_next - t_rise) / CLK_PERIOD), 8, 8, "cpu_clk period");
  @(posedge clk2m);
  t_rise = $time;
  @(negedge clk2m);
  t_fall = $time;
  @(posedge clk2m);
  t_next = $time;
  check_count(int'((t_fall - t_rise) / CLK_PERIOD), 8, 8, "clk2m high cycles");
  check_count(int'((t_next - t_rise) / CLK_PERIOD), 16, 16, "clk2m period");
  @(negedge clk32M);                             // back on the drive edge
endtask

task automatic test_unmapped();
  logic [nx1_pkg::ADDR_W-1:0] addr;
  logic [nx1_pkg::DATA_W-1:0] rd;
  int waits;
  for (int i = 0; i < 2; i++)
  begin
    addr = (i == 0) ? 16'h1a80 : 16'($urandom);  // just past the window, then random
    if (addr >= 16'h1a00 && addr <= 16'h1a7f)
      addr[15] = 1'b1;
    apb_write(addr, 8'h5a);                      // nobody listens
    apb_read(addr, rd, waits);
    check_byte(rd, 8'hff, "unmapped read");
    check_count(waits, 0, 0, "unmapped wait states");
  end
endtask

task automatic test_full_byte();
  logic [nx1_pkg::DATA_W-1:0] tx;
  logic [nx1_pkg::DATA_W-1:0] resp;
  logic [nx1_pkg::DATA_W-1:0] rd;
  int waits;
  tx   = 8'($urandom);
  resp = 8'($urandom);
  arm_card(resp);
  apb_write(window_addr(1'b0, 1'b1, 4'd8), tx);
  check_bit(mmc_cs, 1'b0, "mmc_cs during full byte");
  wait_shift_done(8);
  check_count(sclk_rises, 8, 8, "mmc_clk rises, full byte");
  check_byte(dout_rec, tx, "mmc_dout bits lsb first");
  apb_read(window_addr(1'b0, 1'b1, 4'd0), rd, waits);
  check_byte(rd, resp, "received byte");
endtask

task automatic test_back_pressure();
  logic [nx1_pkg::DATA_W-1:0] tx;
  logic [nx1_pkg::DATA_W-1:0] resp;
  logic [nx1_pkg::DATA_W-1:0] rd;
  int waits;
  tx   = 8'($urandom);
  resp = 8'($urandom);
  arm_card(resp);
  apb_write(window_addr(1'b0, 1'b1, 4'd8), tx);
  apb_read(window_addr(1'b0, 1'b1, 4'd0), rd, waits);   // lands mid transfer
  check_count(waits, 1, 2 * 8 + 2, "wait states behind transfer");
  check_bit(mmc_clk, 1'b0, "mmc_clk idle at read completion");
  check_count(sclk_rises, 8, 8, "mmc_clk rises before read completes");
  check_byte(dout_rec, tx, "mmc_dout bits, stalled read");
  check_byte(rd, resp, "byte returned after stall");
endtask

task automatic test_partial_shift();
  logic [nx1_pkg::DATA_W-1:0] prev;
  logic [nx1_pkg::DATA_W-1:0] junk;
  logic [nx1_pkg::DATA_W-1:0] rd;
  int waits;
  apb_read(window_addr(1'b0, 1'b0, 4'd0), prev, waits);
  arm_card(8'hff);                               // ones on din, gated off by select
  junk = 8'($urandom);
  apb_write(window_addr(1'b1, 1'b0, 4'd4), junk);
  check_bit(mmc_cs, 1'b1, "mmc_cs with select off");
  apb_read(window_addr(1'b0, 1'b0, 4'd0), rd, waits);
  check_count(sclk_rises, 4, 4, "mmc_clk rises, 4 bit shift");
  check_byte(rd, prev >> 4, "register after 4 bit shift");
endtask

task automatic test_ipl_reset();
  logic [nx1_pkg::DATA_W-1:0] tx;
  logic [nx1_pkg::DATA_W-1:0] rd;
  int waits;
  tx = 8'($urandom);
  arm_card(8'($urandom));
  apb_write(window_addr(1'b0, 1'b1, 4'd8), tx);
  repeat (3) @(negedge clk32M);                  // engine mid byte
  ipl_n = 1'b0;
  repeat (4) @(negedge clk32M);
  ipl_n = 1'b1;
  @(negedge clk32M);
  check_bit(mmc_cs, 1'b1, "mmc_cs after ipl");
  check_bit(mmc_clk, 1'b0, "mmc_clk after ipl");
  apb_read(window_addr(1'b0, 1'b1, 4'd0), rd, waits);
  check_byte(rd, 8'h00, "shift register after ipl");
  check_count(waits, 0, 0, "wait states after ipl");
endtask

`endif

//--- test/tb_nx1_io.sv
`default_nettype none

module tb_nx1_io;

  localparam int CLK_PERIOD     = 10;
  localparam int TIMEOUT_CYCLES = 5000;     // whole run is a few hundred cycles

  logic                         clk32M;
  logic                         clk_reset;
  logic                         ipl_n;
  logic                         psel, penable, pwrite;   // apb strobes
  logic [nx1_pkg::ADDR_W-1:0]   paddr;
  logic [nx1_pkg::DATA_W-1:0]   pwdata;
  logic [nx1_pkg::DATA_W-1:0]   prdata;
  logic                         pready;
  logic                         mmc_clk, mmc_cs, mmc_dout, mmc_din;
  logic                         cpu_clk, clk2m;

  // card model
  logic [nx1_pkg::DATA_W-1:0]   resp_byte;    // card answer sent lsb first
  logic [nx1_pkg::DATA_W-1:0]   dout_rec;     // bits seen on mmc_dout
  logic                         sclk_prev;
  int                           bit_idx;
  int                           sclk_rises;

  int                           byte_errs;
  int                           bit_errs;
  int                           count_errs;
  int                           other_errs;   // engine stalls with no value to compare
  int                           cycle_cnt;

  nx1_io_top DUT (.*);

  // --------------------
  // clock
  // --------------------
  initial
  begin
    clk32M = 1'b0;
    forever #(CLK_PERIOD / 2) clk32M = ~clk32M;
  end

  // --------------------
  // mmc card model
  // --------------------
  // mmc_clk is high for exactly one clk32M cycle per bit
  always @(negedge clk32M)
  begin
    if (mmc_clk && !sclk_prev)
      sclk_rises++;
    if (mmc_clk)
    begin
      if (bit_idx < 8)
        dout_rec[bit_idx] = mmc_dout;            // engine bit valid while mmc_clk high
      bit_idx++;
      mmc_din = (bit_idx < 8) ? resp_byte[bit_idx] : 1'b0;  // ready for next rise
    end
    sclk_prev = mmc_clk;
  end

  task automatic arm_card(input logic [nx1_pkg::DATA_W-1:0] resp);
    resp_byte  = resp;
    dout_rec   = '0;
    bit_idx    = 0;
    sclk_rises = 0;
    mmc_din    = resp[0];                        // first bit before first rise
  endtask

  // n serial clocks done and line idle again
  task automatic wait_shift_done(input int n);
    int guard;
    guard = 0;
    while ((sclk_rises < n || mmc_clk) && guard < 4 * n + 8)
    begin
      @(negedge clk32M);
      guard++;
    end
    if (sclk_rises < n || mmc_clk)
    begin
      $display("shift engine stalled, %0d of %0d serial clocks seen", sclk_rises, n);
      other_errs++;
    end
    repeat (4) @(negedge clk32M);                // room for stray clocks
  endtask

  `include "tb_nx1_tests.svh"

  // --------------------
  // timeout
  // --------------------
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk32M);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d clk32M cycles", TIMEOUT_CYCLES);
    $display("Regression failed");
    $finish;
  end

  // main sequence
  initial
  begin
    void'($urandom(32'he41d2381));
    byte_errs  = 0;
    bit_errs   = 0;
    count_errs = 0;
    other_errs = 0;
    clk_reset  = 1'b1;
    ipl_n      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    mmc_din    = 1'b0;
    resp_byte  = '0;
    dout_rec   = '0;
    sclk_prev  = 1'b0;
    bit_idx    = 0;
    sclk_rises = 0;
    repeat (4) @(negedge clk32M);
    clk_reset = 1'b0;
    repeat (20) @(negedge clk32M);               // sys_reset drops after 16
    test_clocks();
    test_unmapped();
    test_full_byte();
    test_back_pressure();
    test_partial_shift();
    test_ipl_reset();
    $display("summary: %0d byte, %0d bit, %0d count, %0d other errors",
             byte_errs, bit_errs, count_errs, other_errs);
    if (byte_errs + bit_errs + count_errs + other_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
